// ==== common/lb_demo_config.svh ====
// Local bus demo slave configuration
// Region codes, mirror depth, PWM width and read fill words
`ifndef LB_DEMO_CONFIG_SVH
`define LB_DEMO_CONFIG_SVH

// Region code in addr[23:16] for mirror and control writes
`define LB_REGION_LOCAL   8'h00
// Region code in addr[23:16] for the status register bank
`define LB_REGION_STATUS  8'h11

// Mirror RAM address width, 32 entries
`define LB_MIRROR_AW      5

// PWM counter width, one period is 1024 cycles
`define LB_PWM_W          10

// Returned for an unused status index, reads as "zzzz"
`define LB_FILL_UNKNOWN   32'h7a7a7a7a
// Returned for an unmapped region or the reserved ROM window
`define LB_FILL_UNMAPPED  32'hdeadbeef

`endif

// ==== common/lb_demo_pkg.sv ====
// Local bus demo slave types
// Bus address, data and duty types plus the status bank index map
`default_nettype none

package lb_demo_pkg;

	// Local bus address, region lives in the top byte
	typedef logic [23:0] lb_addr_t;

	// Local bus data word
	typedef logic [31:0] lb_data_t;

	// LED duty factor, scaled by 4 against the PWM counter
	typedef logic [7:0] duty_t;

	// Status bank register index, taken from addr[3:0]
	typedef enum logic [3:0] {
		IDX_HELLO_0 = 4'd0,
		IDX_HELLO_1 = 4'd1,
		IDX_HELLO_2 = 4'd2,
		IDX_HELLO_3 = 4'd3,
		// Cross-domain fault pulses seen so far
		IDX_FAULT   = 4'd4,
		IDX_SCRATCH = 4'd5,
		// Counts PWM wraps
		IDX_UPTIME  = 4'd6
	} status_idx_t;

endpackage

`default_nettype wire

// ==== lb_status/lb_status_bank.sv ====
// Status register bank, first read cycle of region 0x11
// Greeting words, cross-domain fault counter, uptime counter
// and a registered copy of the scratch input
`default_nettype none

`include "lb_demo_config.svh"

module lb_status_bank import lb_demo_pkg::*; (
	input  logic     clk,
	input  logic     rst,
	input  lb_addr_t lb_addr,
	input  logic     lb_strobe,
	input  logic     lb_rd,
	input  logic     xdomain_fault,
	input  lb_data_t scratch_in,
	input  logic     uptime_tick,
	output lb_data_t status_word
);

	// Fixed ASCII greeting, proves the read path end to end
	localparam lb_data_t HELLO_0 = "Hell";
	localparam lb_data_t HELLO_1 = "o wo";
	localparam lb_data_t HELLO_2 = "rld!";
	localparam lb_data_t HELLO_3 = "(::)";

	logic        rd_stb;
	logic [15:0] fault_count;
	logic [31:0] uptime;
	lb_data_t    scratch_in_r;
	status_idx_t idx;

	assign rd_stb = lb_strobe & lb_rd;
	assign idx    = status_idx_t'(lb_addr[3:0]);

	// ==================================================================
	// Diagnostic counters
	// ==================================================================

	// Fault pulses already arrive in the clk domain
	// Expect a burst at startup while the clock trees settle
	always_ff @(posedge clk) begin
		if (rst) begin
			fault_count <= 16'd0;
		end else if (xdomain_fault) begin
			fault_count <= fault_count + 16'd1;
		end
	end

	// Uptime in PWM periods, wraps after many hours
	always_ff @(posedge clk) begin
		if (rst) begin
			uptime <= 32'd0;
		end else if (uptime_tick) begin
			uptime <= uptime + 32'd1;
		end
	end

	// Single register stage so the scratch word is clearly in clk domain
	always_ff @(posedge clk) begin
		if (rst) begin
			scratch_in_r <= '0;
		end else begin
			scratch_in_r <= scratch_in;
		end
	end

	// ==================================================================
	// First read cycle
	// ==================================================================

	// Word is captured on the read strobe, the mux picks it up next edge
	always_ff @(posedge clk) begin
		if (rd_stb) begin
			case (idx)
				IDX_HELLO_0: status_word <= HELLO_0;
				IDX_HELLO_1: status_word <= HELLO_1;
				IDX_HELLO_2: status_word <= HELLO_2;
				IDX_HELLO_3: status_word <= HELLO_3;
				// Counter is zero extended to a full word
				IDX_FAULT:   status_word <= {16'd0, fault_count};
				IDX_SCRATCH: status_word <= scratch_in_r;
				IDX_UPTIME:  status_word <= uptime;
				default:     status_word <= `LB_FILL_UNKNOWN;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== hdl/lb_mirror_ram.sv ====
// Mirror RAM for the local region
// Every local write is stored and read back with one cycle of latency
`default_nettype none

`include "lb_demo_config.svh"

module lb_mirror_ram import lb_demo_pkg::*; (
	input  logic     clk,
	input  lb_addr_t lb_addr,
	input  logic     lb_strobe,
	input  logic     lb_rd,
	input  lb_data_t lb_wdata,
	output lb_data_t mirror_word
);

	localparam int DEPTH = 1 << `LB_MIRROR_AW;

	lb_data_t                 mem [0:DEPTH-1];
	logic                     local_wr;
	logic                     rd_stb;
	logic [`LB_MIRROR_AW-1:0] word_addr;

	// Region decoded here so only bus signals enter the block
	assign local_wr  = lb_strobe & ~lb_rd & (lb_addr[23:16] == `LB_REGION_LOCAL);
	assign rd_stb    = lb_strobe & lb_rd;
	assign word_addr = lb_addr[`LB_MIRROR_AW-1:0];

	// Write port
	always_ff @(posedge clk) begin
		if (local_wr) begin
			mem[word_addr] <= lb_wdata;
		end
	end

	// Read port, held between read strobes
	always_ff @(posedge clk) begin
		if (rd_stb) begin
			mirror_word <= mem[word_addr];
		end
	end

endmodule

`default_nettype wire

// ==== hdl/lb_read_mux.sv ====
// Local bus read multiplexer, second read cycle
// Selects a first-cycle word by the delayed address region
// and presents it with a one-cycle valid pulse
`default_nettype none

`include "lb_demo_config.svh"

module lb_read_mux import lb_demo_pkg::*; (
	input  logic     clk,
	input  logic     rst,
	input  lb_addr_t lb_addr,
	input  logic     lb_strobe,
	input  logic     lb_rd,
	input  lb_data_t status_word,
	input  lb_data_t mirror_word,
	output lb_data_t lb_rdata,
	output logic     lb_rvalid
);

	logic       rd_r;
	logic [7:0] region_r;
	// Reserved ROM window xxx800 through xxxfff
	logic       rom_win_r;

	// Stage one, track the read and its address
	always_ff @(posedge clk) begin
		if (rst) begin
			rd_r <= 1'b0;
		end else begin
			rd_r <= lb_strobe & lb_rd;
		end
	end

	always_ff @(posedge clk) begin
		if (lb_strobe & lb_rd) begin
			region_r  <= lb_addr[23:16];
			rom_win_r <= lb_addr[11];
		end
	end

	// Stage two, valid pulse follows every tracked read
	always_ff @(posedge clk) begin
		if (rst) begin
			lb_rvalid <= 1'b0;
		end else begin
			lb_rvalid <= rd_r;
		end
	end

	// ROM window wins over any region match
	always_ff @(posedge clk) begin
		if (rd_r) begin
			if (rom_win_r) begin
				lb_rdata <= `LB_FILL_UNMAPPED;
			end else if (region_r == `LB_REGION_LOCAL) begin
				lb_rdata <= mirror_word;
			end else if (region_r == `LB_REGION_STATUS) begin
				lb_rdata <= status_word;
			end else begin
				lb_rdata <= `LB_FILL_UNMAPPED;
			end
		end
	end

endmodule

`default_nettype wire

// ==== hdl/lb_ctrl_regs.sv ====
// Control registers of the local region
// Write decode for user LED, LED duty factors and scratch output;
// PWM LED drive and the uptime tick from the PWM counter carry
`default_nettype none

`include "lb_demo_config.svh"

module lb_ctrl_regs import lb_demo_pkg::*; (
	input  logic     clk,
	input  logic     rst,
	input  lb_addr_t lb_addr,
	input  logic     lb_strobe,
	input  logic     lb_rd,
	input  lb_data_t lb_wdata,
	output logic     led_user_mode,
	output logic     led1,
	output logic     led2,
	output lb_data_t scratch_out,
	output logic     uptime_tick
);

	logic                local_wr;
	duty_t               duty1;
	duty_t               duty2;
	logic [`LB_PWM_W-1:0] pwm_cnt;
	logic [`LB_PWM_W:0]   pwm_next;
	logic [`LB_PWM_W-1:0] duty1_cmp;
	logic [`LB_PWM_W-1:0] duty2_cmp;

	assign local_wr = lb_strobe & ~lb_rd & (lb_addr[23:16] == `LB_REGION_LOCAL);

	// ==================================================================
	// Write decode
	// ==================================================================

	always_ff @(posedge clk) begin
		if (rst) begin
			led_user_mode <= 1'b0;
			duty1         <= '0;
			duty2         <= '0;
			scratch_out   <= '0;
		end else if (local_wr) begin
			case (lb_addr[3:0])
				4'd1: led_user_mode <= lb_wdata[0];
				4'd2: duty1         <= lb_wdata[7:0];
				4'd3: duty2         <= lb_wdata[7:0];
				4'd7: scratch_out   <= lb_wdata;
				// Other offsets only land in the mirror
				default: ;
			endcase
		end
	end

	// ==================================================================
	// PWM and uptime tick
	// ==================================================================

	// Extra top bit catches the wrap
	assign pwm_next  = {1'b0, pwm_cnt} + {{`LB_PWM_W{1'b0}}, 1'b1};

	// Duty of 255 gives 1020 high cycles out of 1024
	assign duty1_cmp = {duty1, 2'b00};
	assign duty2_cmp = {duty2, 2'b00};

	always_ff @(posedge clk) begin
		if (rst) begin
			pwm_cnt     <= '0;
			uptime_tick <= 1'b0;
		end else begin
			pwm_cnt     <= pwm_next[`LB_PWM_W-1:0];
			uptime_tick <= pwm_next[`LB_PWM_W];
		end
	end

	// LED level lags the count by one cycle
	always_ff @(posedge clk) begin
		if (rst) begin
			led1 <= 1'b0;
			led2 <= 1'b0;
		end else begin
			led1 <= pwm_cnt < duty1_cmp;
			led2 <= pwm_cnt < duty2_cmp;
		end
	end

endmodule

`default_nettype wire

// ==== hdl/lb_demo_top.sv ====
// Local bus demo slave top level
// Status bank and mirror RAM feed a two-stage read path;
// control registers drive the LEDs and the uptime tick
`default_nettype none

module lb_demo_top import lb_demo_pkg::*; (
	input  logic     clk,
	input  logic     rst,
	// Local bus from the master
	input  lb_addr_t lb_addr,
	input  logic     lb_strobe,
	input  logic     lb_rd,
	input  lb_data_t lb_wdata,
	output lb_data_t lb_rdata,
	output logic     lb_rvalid,
	// Diagnostics and scratch loopback
	input  logic     xdomain_fault,
	input  lb_data_t scratch_in,
	output lb_data_t scratch_out,
	// Board LEDs
	output logic     led_user_mode,
	output logic     led1,
	output logic     led2
);

	// First read cycle results
	lb_data_t status_word;
	lb_data_t mirror_word;

	// One pulse per PWM period
	logic uptime_tick;

	lb_status_bank status_i (
		.clk           (clk),
		.rst           (rst),
		.lb_addr       (lb_addr),
		.lb_strobe     (lb_strobe),
		.lb_rd         (lb_rd),
		.xdomain_fault (xdomain_fault),
		.scratch_in    (scratch_in),
		.uptime_tick   (uptime_tick),
		.status_word   (status_word)
	);

	lb_mirror_ram mirror_i (
		.clk         (clk),
		.lb_addr     (lb_addr),
		.lb_strobe   (lb_strobe),
		.lb_rd       (lb_rd),
		.lb_wdata    (lb_wdata),
		.mirror_word (mirror_word)
	);

	lb_read_mux mux_i (
		.clk         (clk),
		.rst         (rst),
		.lb_addr     (lb_addr),
		.lb_strobe   (lb_strobe),
		.lb_rd       (lb_rd),
		.status_word (status_word),
		.mirror_word (mirror_word),
		.lb_rdata    (lb_rdata),
		.lb_rvalid   (lb_rvalid)
	);

	lb_ctrl_regs ctrl_i (
		.clk           (clk),
		.rst           (rst),
		.lb_addr       (lb_addr),
		.lb_strobe     (lb_strobe),
		.lb_rd         (lb_rd),
		.lb_wdata      (lb_wdata),
		.led_user_mode (led_user_mode),
		.led1          (led1),
		.led2          (led2),
		.scratch_out   (scratch_out),
		.uptime_tick   (uptime_tick)
	);

endmodule

`default_nettype wire

// ==== test/lb_demo_assert.sv ====
// Bound checks for the local bus demo slave
// Read valid timing and output levels under reset
`default_nettype none

module lb_demo_assert (
	input logic clk,
	input logic rst,
	input logic lb_strobe,
	input logic lb_rd,
	input logic lb_rvalid,
	input logic led_user_mode,
	input logic led1,
	input logic led2
);
	timeunit 1ns;
	timeprecision 100ps;

	// Failed assertions so far, summed into the testbench result
	int unsigned fail_count = 0;

	// Every read strobe is answered two edges later
	a_valid_after_read : assert property (@(posedge clk) disable iff (rst)
		(lb_strobe && lb_rd) |-> ##2 lb_rvalid)
	else begin
		fail_count++;
		$error("lb_rvalid missing two cycles after a read strobe");
	end

	// No valid pulse without a read two edges earlier
	a_no_stray_valid : assert property (@(posedge clk) disable iff (rst)
		lb_rvalid |-> $past(lb_strobe && lb_rd, 2))
	else begin
		fail_count++;
		$error("lb_rvalid high without a matching read strobe");
	end

	// Synchronous reset clears valid and LEDs on the next edge
	a_reset_levels : assert property (@(posedge clk)
		rst |=> (!lb_rvalid && !led_user_mode && !led1 && !led2))
	else begin
		fail_count++;
		$error("lb_rvalid or an LED not low after a reset cycle");
	end

endmodule

bind lb_demo_top lb_demo_assert assert_i (
	.clk           (clk),
	.rst           (rst),
	.lb_strobe     (lb_strobe),
	.lb_rd         (lb_rd),
	.lb_rvalid     (lb_rvalid),
	.led_user_mode (led_user_mode),
	.led1          (led1),
	.led2          (led2)
);

`default_nettype wire

// ==== test/lb_demo_tb.sv ====
// Testbench for the local bus demo slave
// Table-driven region reads, mirror read-back, diagnostics, control and PWM
`default_nettype none

`include "lb_demo_config.svh"

module lb_demo_tb import lb_demo_pkg::*; ();
	timeunit 1ns;
	timeprecision 100ps;

	// Longest wait for a read valid, in cycles
	localparam int TIMEOUT = 16;

	// One table row, either a bus write or a read with its expected word
	typedef struct packed {
		logic     wr;
		lb_addr_t addr;
		lb_data_t wdata;
		lb_data_t exp;
	} step_t;

	logic     clk;
	logic     rst;
	lb_addr_t lb_addr;
	logic     lb_strobe;
	logic     lb_rd;
	lb_data_t lb_wdata;
	lb_data_t lb_rdata;
	logic     lb_rvalid;
	logic     xdomain_fault;
	lb_data_t scratch_in;
	lb_data_t scratch_out;
	logic     led_user_mode;
	logic     led1;
	logic     led2;

	step_t       steps [$];
	logic [15:0] lfsr;
	int          error_count;
	int          check_count;
	int          test_count;
	int          test_start_errors;
	string       test_name;

	lb_demo_top dut_i (
		.clk           (clk),
		.rst           (rst),
		.lb_addr       (lb_addr),
		.lb_strobe     (lb_strobe),
		.lb_rd         (lb_rd),
		.lb_wdata      (lb_wdata),
		.lb_rdata      (lb_rdata),
		.lb_rvalid     (lb_rvalid),
		.xdomain_fault (xdomain_fault),
		.scratch_in    (scratch_in),
		.scratch_out   (scratch_out),
		.led_user_mode (led_user_mode),
		.led1          (led1),
		.led2          (led2)
	);

	// 100 ns clock
	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// ==================================================================
	// Compare tasks and test bookkeeping
	// ==================================================================

	task automatic check_word(input string name, input lb_data_t exp, input lb_data_t got);
		check_count++;
		if (got !== exp) begin
			error_count++;
			$display("ERR %0t %s expected %h got %h", $time, name, exp, got);
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic got);
		check_count++;
		if (got !== exp) begin
			error_count++;
			$display("ERR %0t %s expected %b got %b", $time, name, exp, got);
		end
	endtask

	// High time over one PWM period is duty times 4
	task automatic check_duty(input string name, input int high_count, input duty_t duty);
		int expected;
		expected = int'(duty) * 4;
		check_count++;
		if (high_count != expected) begin
			error_count++;
			$display("ERR %0t %s expected %0d high cycles got %0d",
				$time, name, expected, high_count);
		end
	endtask

	task automatic begin_test(input string name);
		test_name = name;
		test_start_errors = error_count;
		test_count++;
	endtask

	task automatic end_test();
		if (error_count == test_start_errors) begin
			$display("test %0d %s: pass", test_count, test_name);
		end else begin
			$display("test %0d %s: fail with %0d mismatches", test_count, test_name,
				error_count - test_start_errors);
		end
	endtask

	// ==================================================================
	// Stimulus helpers
	// ==================================================================

	// Fibonacci LFSR, taps 16 14 13 11
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	// One LFSR step per data bit
	task automatic rand_word(output lb_data_t w);
		for (int b = 0; b < 32; b++) begin
			lfsr = lfsr_step(lfsr);
			w[b] = lfsr[0];
		end
	endtask

	task automatic add_step(input logic wr, input lb_addr_t addr, input lb_data_t wdata,
		input lb_data_t exp);
		step_t s;
		s.wr = wr;
		s.addr = addr;
		s.wdata = wdata;
		s.exp = exp;
		steps.push_back(s);
	endtask

	// Returns on the falling edge after the write was sampled
	task automatic bus_write(input lb_addr_t addr, input lb_data_t data);
		@(negedge clk);
		lb_addr = addr;
		lb_wdata = data;
		lb_rd = 1'b0;
		lb_strobe = 1'b1;
		@(negedge clk);
		lb_strobe = 1'b0;
	endtask

	// Counts falling edges until lb_rvalid, bounded by TIMEOUT
	task automatic wait_valid(output int waited, output logic ok);
		waited = 0;
		ok = 1'b0;
		while (!ok && waited < TIMEOUT) begin
			@(negedge clk);
			waited++;
			if (lb_rvalid) begin
				ok = 1'b1;
			end
		end
		if (!ok) begin
			error_count++;
			$display("Timeout at %0t: no read valid within %0d cycles", $time, TIMEOUT);
		end
	endtask

	task automatic bus_read(input lb_addr_t addr, output lb_data_t data);
		int   waited;
		logic ok;
		@(negedge clk);
		lb_addr = addr;
		lb_rd = 1'b1;
		lb_strobe = 1'b1;
		@(negedge clk);
		lb_strobe = 1'b0;
		lb_rd = 1'b0;
		wait_valid(waited, ok);
		data = lb_rdata;
		// Valid is set one edge after the strobe edge and shows at the first falling edge here
		if (ok && waited != 1) begin
			error_count++;
			$display("Read of %h at %0t: valid not two edges after the strobe, waited %0d",
				addr, $time, waited);
		end
	endtask

	// Two reads on consecutive cycles, both in flight at once
	task automatic read_pair(input lb_addr_t addr_a, input lb_addr_t addr_b,
		input lb_data_t exp_a, input lb_data_t exp_b);
		int   waited;
		logic ok;
		@(negedge clk);
		lb_addr = addr_a;
		lb_rd = 1'b1;
		lb_strobe = 1'b1;
		@(negedge clk);
		lb_addr = addr_b;
		// First valid shows while the second strobe is being sampled
		wait_valid(waited, ok);
		lb_strobe = 1'b0;
		lb_rd = 1'b0;
		if (ok && waited != 1) begin
			error_count++;
			$display("Back-to-back read of %h: valid came at the wrong cycle", addr_a);
		end
		check_word($sformatf("lb_rdata[%h] first of pair", addr_a), exp_a, lb_rdata);
		@(negedge clk);
		check_bit("lb_rvalid second of pair", 1'b1, lb_rvalid);
		check_word($sformatf("lb_rdata[%h] second of pair", addr_b), exp_b, lb_rdata);
		@(negedge clk);
		check_bit("lb_rvalid after pair", 1'b0, lb_rvalid);
	endtask

	// Greeting words, fill words and a region-filtered mirror write
	task automatic load_table();
		add_step(1'b0, 24'h110000, '0, "Hell");
		add_step(1'b0, 24'h110001, '0, "o wo");
		add_step(1'b0, 24'h110002, '0, "rld!");
		add_step(1'b0, 24'h110003, '0, "(::)");
		add_step(1'b0, 24'h110009, '0, 32'h7a7a7a7a);
		add_step(1'b0, 24'h050000, '0, 32'hdeadbeef);
		add_step(1'b0, 24'h000800, '0, 32'hdeadbeef);
		// ROM window overrides the status region
		add_step(1'b0, 24'h110800, '0, 32'hdeadbeef);
		add_step(1'b1, 24'h00001f, 32'h1234abcd, '0);
		add_step(1'b0, 24'h00001f, '0, 32'h1234abcd);
		add_step(1'b1, 24'h05001f, 32'hffffffff, '0);
		add_step(1'b0, 24'h00001f, '0, 32'h1234abcd);
	endtask

	// ==================================================================
	// Test sequence
	// ==================================================================

	initial begin : stimulus
		lb_data_t mirror_exp [0:31];
		lb_data_t data;
		lb_data_t u1;
		lb_data_t u2;
		duty_t    duties [0:2];
		duty_t    d1;
		duty_t    d2;
		int       h1;
		int       h2;

		rst = 1'b1;
		lb_addr = '0;
		lb_strobe = 1'b0;
		lb_rd = 1'b0;
		lb_wdata = '0;
		xdomain_fault = 1'b0;
		scratch_in = '0;
		lfsr = 16'd44;
		error_count = 0;
		check_count = 0;
		test_count = 0;
		load_table();

		repeat (16) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		begin_test("reset state");
		@(negedge clk);
		check_bit("lb_rvalid", 1'b0, lb_rvalid);
		check_bit("led_user_mode", 1'b0, led_user_mode);
		check_bit("led1", 1'b0, led1);
		check_bit("led2", 1'b0, led2);
		check_word("scratch_out", '0, scratch_out);
		end_test();

		begin_test("region reads");
		foreach (steps[i]) begin
			if (steps[i].wr) begin
				bus_write(steps[i].addr, steps[i].wdata);
			end else begin
				bus_read(steps[i].addr, data);
				check_word($sformatf("lb_rdata[%h]", steps[i].addr), steps[i].exp, data);
			end
		end
		// Same rows again, issued in overlapping pairs
		for (int i = 0; i + 1 < steps.size(); i++) begin
			if (!steps[i].wr && !steps[i + 1].wr) begin
				read_pair(steps[i].addr, steps[i + 1].addr, steps[i].exp, steps[i + 1].exp);
			end
		end
		end_test();

		begin_test("mirror");
		for (int a = 0; a < 32; a++) begin
			rand_word(mirror_exp[a]);
			bus_write(lb_addr_t'(a), mirror_exp[a]);
		end
		for (int a = 0; a < 32; a++) begin
			bus_read(lb_addr_t'(a), data);
			check_word($sformatf("mirror[%0d]", a), mirror_exp[a], data);
		end
		// Nonlocal write must not reach the mirror
		bus_write(24'h05000a, ~mirror_exp[10]);
		bus_read(24'h00000a, data);
		check_word("mirror[10] after nonlocal write", mirror_exp[10], data);
		end_test();

		begin_test("fault count and scratch input");
		repeat (5) begin
			@(negedge clk);
			xdomain_fault = 1'b1;
			@(negedge clk);
			xdomain_fault = 1'b0;
		end
		bus_read(24'h110004, data);
		check_word("fault count", 32'd5, data);
		@(negedge clk);
		scratch_in = 32'h5c7a0b1e;
		@(negedge clk);
		bus_read(24'h110005, data);
		check_word("scratch input", 32'h5c7a0b1e, data);
		end_test();

		begin_test("control registers");
		bus_write(24'h000001, 32'h00000001);
		check_bit("led_user_mode", 1'b1, led_user_mode);
		// Only bit 0 counts
		bus_write(24'h000001, 32'hfffffffe);
		check_bit("led_user_mode", 1'b0, led_user_mode);
		bus_write(24'h000007, 32'hc0ffee42);
		check_word("scratch_out", 32'hc0ffee42, scratch_out);
		end_test();

		begin_test("pwm duty");
		duties[0] = 8'd0;
		duties[1] = 8'd37;
		duties[2] = 8'd255;
		for (int i = 0; i < 3; i++) begin
			d1 = duties[i];
			d2 = duties[(i + 1) % 3];
			bus_write(24'h000002, {24'd0, d1});
			bus_write(24'h000003, {24'd0, d2});
			// Let the new duty reach the LED registers
			repeat (2) @(negedge clk);
			h1 = 0;
			h2 = 0;
			repeat (1024) begin
				@(negedge clk);
				h1 += int'(led1);
				h2 += int'(led2);
			end
			check_duty($sformatf("led1 duty %0d", d1), h1, d1);
			check_duty($sformatf("led2 duty %0d", d2), h2, d2);
		end
		end_test();

		begin_test("uptime");
		repeat (2100) @(negedge clk);
		bus_read(24'h110006, u1);
		check_count++;
		if (u1 == 0) begin
			error_count++;
			$display("ERR %0t uptime expected nonzero got %0d", $time, u1);
		end
		repeat (1100) @(negedge clk);
		bus_read(24'h110006, u2);
		check_count++;
		if (u2 < u1) begin
			error_count++;
			$display("ERR %0t uptime expected at least %0d got %0d", $time, u1, u2);
		end
		end_test();

		// Bound assertion failures count as well
		repeat (4) @(negedge clk);
		error_count += int'(dut_i.assert_i.fail_count);
		$display("Summary: %0d tests, %0d checks, %0d failures", test_count, check_count,
			error_count);
		if (error_count == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+common
common/lb_demo_pkg.sv
lb_status/lb_status_bank.sv
hdl/lb_mirror_ram.sv
hdl/lb_read_mux.sv
hdl/lb_ctrl_regs.sv
hdl/lb_demo_top.sv
test/lb_demo_assert.sv
test/lb_demo_tb.sv
